//--- dv/stereo_assertions.sv
`timescale 1ns/1ps

module stereo_assertions (
    input logic cam_clk,
    input logic sys_reset,
    input logic vsync_i,
    input logic hsync_i,
    input logic de_i
);

    // Sync pulses sit in blanking only
    hsync_in_blanking: assert property (@(posedge cam_clk) disable iff (sys_reset)
        !(hsync_i && de_i))
        else $error("hsync and de high in the same cycle");

    vsync_in_blanking: assert property (@(posedge cam_clk) disable iff (sys_reset)
        !(vsync_i && de_i))
        else $error("vsync and de high in the same cycle");

    // --------------------
    // Known outputs
    // --------------------
    controls_known: assert property (@(posedge cam_clk) disable iff (sys_reset)
        !$isunknown({vsync_i, hsync_i, de_i}))
        else $error("video control output is unknown");

endmodule

bind stereo_top stereo_assertions u_stereo_assertions (
    .cam_clk   (cam_clk),
    .sys_reset (sys_reset),
    .vsync_i   (vid_vsync_o),
    .hsync_i   (vid_hsync_o),
    .de_i      (vid_de_o)
);

//--- dv/tb_stereo_top.sv
`timescale 1ns/1ps

module tb_stereo_top;
    import stereo_pkg::*;

    // Shrunk raster
    localparam int H_TOTAL      = 560;
    localparam int H_DISP       = 512;
    localparam int H_SYNC_START = 520;
    localparam int H_SYNC_END   = 530;
    localparam int V_TOTAL      = 9;
    localparam int V_DISP       = 6;
    localparam int V_SYNC_START = 7;
    localparam int V_SYNC_END   = 8;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int LINE_GAP = 8;
    localparam logic [31:0] SEED = 32'h27de_e932;

    // --------------------
    // Test table
    // --------------------
    localparam int NUM_TESTS = 4;
    string test_name   [NUM_TESTS] = '{"full_window", "clip_wide_line",
                                       "clip_tall_frame", "refill_frame"};
    int    line_width  [NUM_TESTS] = '{256, 300, 256, 260};
    int    frame_lines [NUM_TESTS] = '{8, 6, 262, 7};
    int    seed_offset [NUM_TESTS] = '{0, 17, 42, 99};

    logic   cam_clk = 1'b0;
    logic   sys_reset;
    logic   cam0_fv_i, cam0_lv_i, cam1_fv_i, cam1_lv_i;
    pixel_t cam0_pixel_i, cam1_pixel_i;
    logic   vid_vsync_o, vid_hsync_o, vid_de_o;
    rgb_t   vid_rgb_o;

    // Expected buffer contents per camera
    fb_data_t    model0 [FB_SIDE*FB_SIDE];
    fb_data_t    model1 [FB_SIDE*FB_SIDE];
    logic [31:0] rng_state;
    int          n_checks, n_errors;
    bit          timed_out;

    stereo_top #(
        .H_TOTAL      (H_TOTAL),
        .H_DISP       (H_DISP),
        .H_SYNC_START (H_SYNC_START),
        .H_SYNC_END   (H_SYNC_END),
        .V_TOTAL      (V_TOTAL),
        .V_DISP       (V_DISP),
        .V_SYNC_START (V_SYNC_START),
        .V_SYNC_END   (V_SYNC_END)
    ) DUT (.*);

    initial begin
        forever #2 cam_clk = ~cam_clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // Left half from camera 1, right half from camera 0
    function automatic rgb_t expected_rgb(input int x, input int y);
        fb_data_t grey;
        if (x < FB_SIDE) grey = model1[fb_addr_t'(y * FB_SIDE + x)];
        else             grey = model0[fb_addr_t'(y * FB_SIDE + x - FB_SIDE)];
        return {3{grey}};
    endfunction

    task automatic check_rgb(input string what, input rgb_t expected, input rgb_t actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("FAIL %s: expected %06h, actual %06h", what, expected, actual);
        end
    endtask

    task automatic check_count(input string what, input int expected, input int actual);
        n_checks++;
        if (actual != expected) begin
            n_errors++;
            $display("FAIL %s: expected %0d, actual %0d", what, expected, actual);
        end
    endtask

    // --------------------
    // Camera side
    // --------------------
    task automatic drive_frame(input int width, input int lines, input int ofs);
        pixel_t p0, p1;
        rng_state = SEED + 32'(ofs);
        cam0_fv_i = 1'b1;
        cam1_fv_i = 1'b1;
        repeat (4) @(negedge cam_clk);
        for (int row = 0; row < lines; row++) begin
            for (int col = 0; col < width; col++) begin
                rng_state = xorshift32(rng_state);
                p0 = rng_state[PIXEL_W-1:0];
                rng_state = xorshift32(rng_state);
                p1 = rng_state[PIXEL_W-1:0];
                cam0_lv_i = 1'b1;
                cam1_lv_i = 1'b1;
                cam0_pixel_i = p0;
                cam1_pixel_i = p1;
                // Model keeps the window only and drops the two low pixel bits
                if (col < FB_SIDE && row < FB_SIDE) begin
                    model0[fb_addr_t'(row * FB_SIDE + col)] = fb_data_t'(p0 >> 2);
                    model1[fb_addr_t'(row * FB_SIDE + col)] = fb_data_t'(p1 >> 2);
                end
                @(negedge cam_clk);
            end
            cam0_lv_i = 1'b0;
            cam1_lv_i = 1'b0;
            repeat (LINE_GAP) @(negedge cam_clk);
        end
        cam0_fv_i = 1'b0;
        cam1_fv_i = 1'b0;
        repeat (4) @(negedge cam_clk);
    endtask

    // --------------------
    // Display side
    // --------------------
    task automatic wait_vsync(input logic level);
        int n;
        n = 0;
        while (vid_vsync_o !== level && n < 2 * FRAME_CYCLES) begin
            @(negedge cam_clk);
            n++;
        end
        if (vid_vsync_o !== level) begin
            $display("ERROR: vsync did not reach %0d within %0d cycles", level, n);
            timed_out = 1'b1;
        end
    endtask

    task automatic scan_frame(input string name);
        int n, x, y, hs_len;
        logic prev_de, prev_hs;
        wait_vsync(1'b1);
        if (timed_out) return;
        wait_vsync(1'b0);
        if (timed_out) return;
        n = 0;
        x = 0;
        y = 0;
        hs_len = 0;
        prev_de = 1'b0;
        prev_hs = 1'b0;
        while (!vid_vsync_o && n < FRAME_CYCLES) begin
            if (vid_de_o) begin
                check_rgb($sformatf("%s pixel (%0d,%0d)", name, x, y),
                          expected_rgb(x, y), vid_rgb_o);
                x++;
            end else if (prev_de) begin
                check_count({name, " de cycles per line"}, H_DISP, x);
                x = 0;
                y++;
            end
            if (vid_hsync_o) hs_len++;
            else if (prev_hs) begin
                check_count({name, " hsync width"}, H_SYNC_END - H_SYNC_START, hs_len);
                hs_len = 0;
            end
            prev_de = vid_de_o;
            prev_hs = vid_hsync_o;
            @(negedge cam_clk);
            n++;
        end
        if (!vid_vsync_o) begin
            $display("ERROR: display frame of %s did not end within %0d cycles", name, n);
            timed_out = 1'b1;
        end
        check_count({name, " lines with de"}, V_DISP, y);
    endtask

    task automatic check_idle(input string what);
        check_count({what, " vsync"}, 0, int'(vid_vsync_o));
        check_count({what, " hsync"}, 0, int'(vid_hsync_o));
        check_count({what, " de"}, 0, int'(vid_de_o));
    endtask

    initial begin
        int c0, e0;
        sys_reset = 1'b1;
        cam0_fv_i = 1'b0;
        cam0_lv_i = 1'b0;
        cam0_pixel_i = '0;
        cam1_fv_i = 1'b0;
        cam1_lv_i = 1'b0;
        cam1_pixel_i = '0;
        n_checks = 0;
        n_errors = 0;
        timed_out = 1'b0;
        repeat (10) @(negedge cam_clk);
        check_idle("reset_state in reset");
        sys_reset = 1'b0;
        @(negedge cam_clk);
        check_idle("reset_state after reset");
        $display("test reset_state: %0d checks, %0d errors", n_checks, n_errors);
        for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
            c0 = n_checks;
            e0 = n_errors;
            drive_frame(line_width[t], frame_lines[t], seed_offset[t]);
            scan_frame(test_name[t]);
            $display("test %s: %0d checks, %0d errors", test_name[t],
                     n_checks - c0, n_errors - e0);
        end
        $display("Totals: %0d checks, %0d errors, timeout %0d", n_checks, n_errors, timed_out);
        if (n_errors == 0 && !timed_out) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- rtl/capture_writer.sv
`timescale 1ns/1ps

module capture_writer (
    input  logic              cam_clk,
    input  logic              sys_reset,
    input  logic              fv_i,
    input  logic              lv_i,
    input  stereo_pkg::pixel_t pixel_i,
    fb_write_if.writer        wr
);
    import stereo_pkg::*;

    localparam int COORD_W = $clog2(FB_SIDE);

    logic   lv_q;
    h_cnt_t cam_x;
    v_cnt_t cam_y;
    logic   in_window;

    // --------------------
    // Camera position
    // --------------------
    always_ff @(posedge cam_clk or posedge sys_reset) begin
        if (sys_reset) begin
            lv_q  <= 1'b0;
            cam_x <= '0;
            cam_y <= '0;
        end else begin
            lv_q  <= lv_i;
            cam_x <= lv_i ? cam_x + 1'b1 : '0;
            // Next line starts after lv falls
            if (!fv_i) begin
                cam_y <= '0;
            end else if (lv_q && !lv_i) begin
                cam_y <= cam_y + 1'b1;
            end
        end
    end

    // Pixels beyond the buffer edge are dropped
    assign in_window = (cam_x < H_CNT_W'(FB_SIDE)) && (cam_y < V_CNT_W'(FB_SIDE));

    // --------------------
    // Write port
    // --------------------
    always_ff @(posedge cam_clk or posedge sys_reset) begin
        if (sys_reset) begin
            wr.wr_en <= 1'b0;
            wr.wr_we <= 1'b0;
        end else begin
            wr.wr_en <= lv_i;
            wr.wr_we <= lv_i && in_window;
        end
    end

    always_ff @(posedge cam_clk) begin
        wr.wr_addr <= {cam_y[COORD_W-1:0], cam_x[COORD_W-1:0]};
        wr.wr_data <= pixel_i[PIXEL_W-1 -: FB_DATA_W];
    end

endmodule

//--- rtl/fb_write_if.sv
`timescale 1ns/1ps

interface fb_write_if;
    import stereo_pkg::*;

    // A write happens when both strobes are high
    logic     wr_en;
    logic     wr_we;
    fb_addr_t wr_addr;
    fb_data_t wr_data;

    modport writer (
        output wr_en,
        output wr_we,
        output wr_addr,
        output wr_data
    );

    modport memory (
        input wr_en,
        input wr_we,
        input wr_addr,
        input wr_data
    );

endinterface

//--- rtl/frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer (
    input  logic                 cam_clk,
    fb_write_if.memory           wr,
    input  stereo_pkg::fb_addr_t rd_addr_i,
    output stereo_pkg::fb_data_t rd_data_o
);
    import stereo_pkg::*;

    localparam int DEPTH = FB_SIDE * FB_SIDE;

    fb_data_t mem [DEPTH];
    fb_data_t mem_q;

    // --------------------
    // Write side
    // --------------------
    always_ff @(posedge cam_clk) begin
        if (wr.wr_en && wr.wr_we) begin
            mem[wr.wr_addr] <= wr.wr_data;
        end
    end

    // --------------------
    // Read side
    // --------------------

    // RAM register, then output register
    always_ff @(posedge cam_clk) begin
        mem_q     <= mem[rd_addr_i];
        rd_data_o <= mem_q;
    end

endmodule

//--- rtl/stereo_mixer.sv
`timescale 1ns/1ps

module stereo_mixer (
    input  logic                 cam_clk,
    input  logic                 sys_reset,
    video_timing_if.sink         vt,
    output stereo_pkg::fb_addr_t rd_addr_o,
    input  stereo_pkg::fb_data_t view0_data_i,
    input  stereo_pkg::fb_data_t view1_data_i,
    output logic                 vid_vsync_o,
    output logic                 vid_hsync_o,
    output logic                 vid_de_o,
    output stereo_pkg::rgb_t     vid_rgb_o
);
    import stereo_pkg::*;

    localparam int COORD_W = $clog2(FB_SIDE);

    logic [1:0] vsync_d;
    logic [1:0] hsync_d;
    logic [1:0] de_d;
    logic [1:0] sel_d;

    // Both buffers share one address
    assign rd_addr_o = {vt.pos_y[COORD_W-1:0], vt.pos_x[COORD_W-1:0]};

    // --------------------
    // Read latency match
    // --------------------

    // Two stages, same as the buffer read path
    always_ff @(posedge cam_clk or posedge sys_reset) begin
        if (sys_reset) begin
            vsync_d <= '0;
            hsync_d <= '0;
            de_d    <= '0;
            sel_d   <= '0;
        end else begin
            vsync_d <= {vsync_d[0], vt.vsync};
            hsync_d <= {hsync_d[0], vt.hsync};
            de_d    <= {de_d[0], vt.de};
            sel_d   <= {sel_d[0], vt.pos_x[COORD_W]};
        end
    end

    assign vid_vsync_o = vsync_d[1];
    assign vid_hsync_o = hsync_d[1];
    assign vid_de_o    = de_d[1];

    // Right half shows camera 0, grey on all channels
    assign vid_rgb_o = sel_d[1] ? {3{view0_data_i}} : {3{view1_data_i}};

endmodule

//--- rtl/stereo_pkg.sv
package stereo_pkg;

    // --------------------
    // Camera stream
    // --------------------

    // Raw sensor pixel
    localparam int PIXEL_W = 10;
    typedef logic [PIXEL_W-1:0] pixel_t;

    // --------------------
    // Frame buffer
    // --------------------

    // Stored grey value, top bits of the sensor pixel
    localparam int FB_DATA_W = 8;
    typedef logic [FB_DATA_W-1:0] fb_data_t;

    localparam int FB_SIDE = 256;

    // Row in the upper byte, column in the lower byte
    localparam int FB_ADDR_W = 16;
    typedef logic [FB_ADDR_W-1:0] fb_addr_t;

    // --------------------
    // Display
    // --------------------

    // Three 8-bit channels, R on top
    typedef logic [3*FB_DATA_W-1:0] rgb_t;

    // Position counters, shared by camera and raster side
    localparam int H_CNT_W = 12;
    typedef logic [H_CNT_W-1:0] h_cnt_t;

    localparam int V_CNT_W = 11;
    typedef logic [V_CNT_W-1:0] v_cnt_t;

endpackage

//--- rtl/stereo_top.sv
`timescale 1ns/1ps

module stereo_top #(
    parameter int H_TOTAL      = 1650,
    parameter int H_DISP       = 1280,
    parameter int H_SYNC_START = 1390,
    parameter int H_SYNC_END   = 1430,
    parameter int V_TOTAL      = 750,
    parameter int V_DISP       = 720,
    parameter int V_SYNC_START = 725,
    parameter int V_SYNC_END   = 730
) (
    input  logic               cam_clk,
    input  logic               sys_reset,
    input  logic               cam0_fv_i,
    input  logic               cam0_lv_i,
    input  stereo_pkg::pixel_t cam0_pixel_i,
    input  logic               cam1_fv_i,
    input  logic               cam1_lv_i,
    input  stereo_pkg::pixel_t cam1_pixel_i,
    output logic               vid_vsync_o,
    output logic               vid_hsync_o,
    output logic               vid_de_o,
    output stereo_pkg::rgb_t   vid_rgb_o
);
    import stereo_pkg::*;

    fb_addr_t rd_addr;
    fb_data_t view0_data;
    fb_data_t view1_data;

    fb_write_if     cam0_wr ();
    fb_write_if     cam1_wr ();
    video_timing_if vt ();

    // --------------------
    // Capture paths
    // --------------------
    capture_writer u_capture_cam0 (
        .cam_clk   (cam_clk),
        .sys_reset (sys_reset),
        .fv_i      (cam0_fv_i),
        .lv_i      (cam0_lv_i),
        .pixel_i   (cam0_pixel_i),
        .wr        (cam0_wr.writer)
    );

    frame_buffer u_fb_cam0 (
        .cam_clk   (cam_clk),
        .wr        (cam0_wr.memory),
        .rd_addr_i (rd_addr),
        .rd_data_o (view0_data)
    );

    capture_writer u_capture_cam1 (
        .cam_clk   (cam_clk),
        .sys_reset (sys_reset),
        .fv_i      (cam1_fv_i),
        .lv_i      (cam1_lv_i),
        .pixel_i   (cam1_pixel_i),
        .wr        (cam1_wr.writer)
    );

    frame_buffer u_fb_cam1 (
        .cam_clk   (cam_clk),
        .wr        (cam1_wr.memory),
        .rd_addr_i (rd_addr),
        .rd_data_o (view1_data)
    );

    // --------------------
    // Display path
    // --------------------
    sync_generator #(
        .H_TOTAL      (H_TOTAL),
        .H_DISP       (H_DISP),
        .H_SYNC_START (H_SYNC_START),
        .H_SYNC_END   (H_SYNC_END),
        .V_TOTAL      (V_TOTAL),
        .V_DISP       (V_DISP),
        .V_SYNC_START (V_SYNC_START),
        .V_SYNC_END   (V_SYNC_END)
    ) u_sync_generator (
        .cam_clk   (cam_clk),
        .sys_reset (sys_reset),
        .vt        (vt.source)
    );

    stereo_mixer u_stereo_mixer (
        .cam_clk      (cam_clk),
        .sys_reset    (sys_reset),
        .vt           (vt.sink),
        .rd_addr_o    (rd_addr),
        .view0_data_i (view0_data),
        .view1_data_i (view1_data),
        .vid_vsync_o  (vid_vsync_o),
        .vid_hsync_o  (vid_hsync_o),
        .vid_de_o     (vid_de_o),
        .vid_rgb_o    (vid_rgb_o)
    );

endmodule

//--- rtl/sync_generator.sv
`timescale 1ns/1ps

module sync_generator #(
    parameter int H_TOTAL      = 1650,
    parameter int H_DISP       = 1280,
    parameter int H_SYNC_START = 1390,
    parameter int H_SYNC_END   = 1430,
    parameter int V_TOTAL      = 750,
    parameter int V_DISP       = 720,
    parameter int V_SYNC_START = 725,
    parameter int V_SYNC_END   = 730
) (
    input  logic           cam_clk,
    input  logic           sys_reset,
    video_timing_if.source vt
);
    import stereo_pkg::*;

    h_cnt_t h_cnt;
    v_cnt_t v_cnt;
    logic   de_q;

    // --------------------
    // Raster counters
    // --------------------
    always_ff @(posedge cam_clk or posedge sys_reset) begin
        if (sys_reset) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_CNT_W'(H_TOTAL - 1)) begin
            h_cnt <= '0;
            if (v_cnt == V_CNT_W'(V_TOTAL - 1)) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // Registered decode, all three stay aligned
    always_ff @(posedge cam_clk or posedge sys_reset) begin
        if (sys_reset) begin
            vt.de    <= 1'b0;
            vt.hsync <= 1'b0;
            vt.vsync <= 1'b0;
        end else begin
            vt.de    <= (h_cnt < H_CNT_W'(H_DISP)) && (v_cnt < V_CNT_W'(V_DISP));
            vt.hsync <= (h_cnt >= H_CNT_W'(H_SYNC_START)) && (h_cnt < H_CNT_W'(H_SYNC_END));
            vt.vsync <= (v_cnt >= V_CNT_W'(V_SYNC_START)) && (v_cnt < V_CNT_W'(V_SYNC_END));
        end
    end

    // --------------------
    // Raster position
    // --------------------

    // x restarts on hsync, y counts falling edges of de
    always_ff @(posedge cam_clk or posedge sys_reset) begin
        if (sys_reset) begin
            de_q     <= 1'b0;
            vt.pos_x <= '0;
            vt.pos_y <= '0;
        end else begin
            de_q <= vt.de;
            if (vt.vsync) begin
                vt.pos_y <= '0;
            end else if (de_q && !vt.de) begin
                vt.pos_y <= vt.pos_y + 1'b1;
            end
            if (vt.hsync) begin
                vt.pos_x <= '0;
            end else if (vt.de) begin
                vt.pos_x <= vt.pos_x + 1'b1;
            end
        end
    end

endmodule

//--- rtl/video_timing_if.sv
`timescale 1ns/1ps

interface video_timing_if;
    import stereo_pkg::*;

    logic   vsync;
    logic   hsync;
    logic   de;
    // Position of the current de cycle
    h_cnt_t pos_x;
    v_cnt_t pos_y;

    modport source (
        output vsync,
        output hsync,
        output de,
        output pos_x,
        output pos_y
    );

    modport sink (
        input vsync,
        input hsync,
        input de,
        input pos_x,
        input pos_y
    );

endinterface

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the stereo capture testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    --top-module tb_stereo_top \
    -f stereo_capture.f

./obj_dir/Vtb_stereo_top | tee "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
    echo "Testbench reported a failure, see $LOG"
    exit 1
fi

# A run that never reached its end also counts as failed
grep -q "Simulation finished: PASS" "$LOG"

//--- stereo_capture.f
rtl/stereo_pkg.sv
rtl/fb_write_if.sv
rtl/video_timing_if.sv
rtl/capture_writer.sv
rtl/frame_buffer.sv
rtl/sync_generator.sv
rtl/stereo_mixer.sv
rtl/stereo_top.sv
dv/stereo_assertions.sv
dv/tb_stereo_top.sv
